/* hdl/gb_loader_pkg.sv */
// Shared widths, download kinds and bootrom checksum constants for the host loader
`default_nettype none

package gb_loader_pkg;

	////////////////////////////////
	// Host stream widths
	////////////////////////////////

	typedef logic [15:0] host_word_t;
	typedef logic [24:0] host_addr_t;
	typedef logic [7:0] file_index_t;

	// Byte sum over a whole bootrom image
	typedef logic [17:0] checksum_t;

	// Flags 127..96, address 95..64, compare 63..32, replace 31..0
	typedef logic [127:0] cheat_code_t;

	// What the host is currently sending
	typedef enum logic [2:0] {
		dl_none,
		dl_cart,
		dl_cheat,
		dl_cgb_boot,
		dl_dmg_boot,
		dl_sgb_boot,
		dl_other
	} download_kind_t;

	////////////////////////////////
	// Bootrom checksums
	////////////////////////////////

	// In-house CGB bootrom, supports fast boot and GBA mode
	localparam checksum_t MISTER_CGB_CHECKSUM = 18'h2CE10;

	// Original CGB bootrom
	localparam checksum_t ORIGINAL_CGB_CHECKSUM = 18'h2F3EA;

	////////////////////////////////
	// Host file indices
	////////////////////////////////

	// Cartridges also use any index whose low six bits are 1
	localparam file_index_t INDEX_CART_ALT = 8'h80;
	localparam file_index_t INDEX_CHEAT = 8'hFF;
	localparam file_index_t INDEX_CGB_BOOT = 8'd4;
	localparam file_index_t INDEX_DMG_BOOT = 8'd5;
	localparam file_index_t INDEX_SGB_BOOT = 8'd6;

endpackage

`default_nettype wire

/* hdl/download_decoder.sv */
// Host download decoder, classifies the file index and registers the write stream
`timescale 1ns/100ps
`default_nettype none

module download_decoder
	import gb_loader_pkg::*;
(
	input  wire logic           clk_sys,
	input  wire logic           reset,
	input  wire logic           host_download,
	input  wire file_index_t    host_index,
	input  wire logic           host_wr,
	input  wire host_addr_t     host_addr,
	input  wire host_word_t     host_data,
	output download_kind_t      dl_kind,
	output logic                dl_start,
	output logic                dl_wr,
	output host_addr_t          dl_addr,
	output host_word_t          dl_data
);

	download_kind_t kind_next;

	// Index classification, cartridge checks first
	always_comb begin
		if (!host_download)
			kind_next = dl_none;
		else if (host_index[5:0] == 6'h01 || host_index == INDEX_CART_ALT)
			kind_next = dl_cart;
		else if (host_index == INDEX_CHEAT)
			kind_next = dl_cheat;
		else if (host_index == INDEX_CGB_BOOT)
			kind_next = dl_cgb_boot;
		else if (host_index == INDEX_DMG_BOOT)
			kind_next = dl_dmg_boot;
		else if (host_index == INDEX_SGB_BOOT)
			kind_next = dl_sgb_boot;
		else
			kind_next = dl_other;
	end

	////////////////////////////////
	// Kind and start pulse
	////////////////////////////////

	// dl_kind still holds the previous kind when the new one is sampled
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind <= dl_none;
			dl_start <= 1'b0;
			dl_wr <= 1'b0;
		end else begin
			dl_kind <= kind_next;
			dl_start <= (kind_next != dl_none) && (kind_next != dl_kind);
			dl_wr <= host_wr;
		end
	end

	// Write payload, delayed to stay aligned with dl_kind
	always_ff @(posedge clk_sys) begin
		dl_addr <= host_addr;
		dl_data <= host_data;
	end

endmodule

`default_nettype wire

/* hdl/bootrom_monitor.sv */
// Bootrom monitor, tracks custom bootroms, sums the CGB image and gates boot options
`timescale 1ns/100ps
`default_nettype none

module bootrom_monitor
	import gb_loader_pkg::*;
(
	input  wire logic           clk_sys,
	input  wire logic           reset,
	input  wire download_kind_t dl_kind,
	input  wire logic           dl_start,
	input  wire logic           dl_wr,
	input  wire host_word_t     dl_data,
	input  wire logic           is_gbc,
	input  wire logic           fast_boot_req,
	input  wire logic           gba_req,
	output logic                fast_boot_en,
	output logic                boot_gba_en,
	output logic                real_cgb_boot
);

	logic custom_cgb;
	logic custom_dmg;
	checksum_t checksum;
	checksum_t byte_sum;
	logic cgb_write;
	logic fast_boot_avail;
	logic gba_boot_avail;

	assign cgb_write = (dl_kind == dl_cgb_boot) && dl_wr;

	// Both bytes of the current word
	assign byte_sum = checksum_t'(dl_data[15:8]) + checksum_t'(dl_data[7:0]);

	////////////////////////////////
	// Custom bootrom flags
	////////////////////////////////

	// Sticky until reset, a later download never returns to the built-in image
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
		end else begin
			if (cgb_write)
				custom_cgb <= 1'b1;
			if ((dl_kind == dl_dmg_boot) && dl_wr)
				custom_dmg <= 1'b1;
		end
	end

	////////////////////////////////
	// CGB checksum
	////////////////////////////////

	// Restart on each new CGB download, the first word may arrive with the start
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			checksum <= '0;
		end else if (dl_kind == dl_cgb_boot) begin
			if (dl_start)
				checksum <= dl_wr ? byte_sum : '0;
			else if (dl_wr)
				checksum <= checksum + byte_sum;
		end
	end

	////////////////////////////////
	// Boot option gate
	////////////////////////////////

	// Fast boot needs the in-house CGB image, or no custom DMG image on DMG
	assign fast_boot_avail =
		!((is_gbc && custom_cgb && (checksum != MISTER_CGB_CHECKSUM)) ||
		  (!is_gbc && custom_dmg));

	// GBA mode works with the built-in, in-house or original CGB image
	assign gba_boot_avail = !custom_cgb ||
		(checksum == MISTER_CGB_CHECKSUM) ||
		(checksum == ORIGINAL_CGB_CHECKSUM);

	assign real_cgb_boot = (checksum == ORIGINAL_CGB_CHECKSUM);
	assign fast_boot_en = fast_boot_req && fast_boot_avail;
	assign boot_gba_en = gba_req && gba_boot_avail;

endmodule

`default_nettype wire

/* hdl/cheat_code_loader.sv */
// Cheat code loader, builds 128-bit codes from host words and requests a cheat clear
`timescale 1ns/100ps
`default_nettype none

module cheat_code_loader
	import gb_loader_pkg::*;
(
	input  wire logic           clk_sys,
	input  wire logic           reset,
	input  wire download_kind_t dl_kind,
	input  wire logic           dl_wr,
	input  wire host_addr_t     dl_addr,
	input  wire host_word_t     dl_data,
	output cheat_code_t         cheat_code,
	output logic                code_valid,
	output logic                cheats_clear
);

	logic cheat_wr;

	assign cheat_wr = (dl_kind == dl_cheat) && dl_wr;

	////////////////////////////////
	// Code assembly
	////////////////////////////////

	// Each field is a pair of half-words, lower address into the bottom half.
	// Byte order inside a field is left to whoever generates the file
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (dl_addr[3:0])
				4'd0: cheat_code[111:96] <= dl_data;
				4'd2: cheat_code[127:112] <= dl_data;
				4'd4: cheat_code[79:64] <= dl_data;
				4'd6: cheat_code[95:80] <= dl_data;
				4'd8: cheat_code[47:32] <= dl_data;
				4'd10: cheat_code[63:48] <= dl_data;
				4'd12: cheat_code[15:0] <= dl_data;
				4'd14: cheat_code[31:16] <= dl_data;
				default: ;
			endcase
		end
	end

	////////////////////////////////
	// Strobes
	////////////////////////////////

	// Offset 14 completes a code
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= cheat_wr && (dl_addr[3:0] == 4'd14);
	end

	// Clear on a new cheat file, and keep clearing through a cartridge load
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheats_clear <= 1'b0;
		end else begin
			cheats_clear <= (cheat_wr && (dl_addr == '0)) ||
				(dl_kind == dl_cart);
		end
	end

endmodule

`default_nettype wire

/* hdl/gb_loader_top.sv */
// Host loader top level, decoder feeding the bootrom monitor and the cheat loader
`timescale 1ns/100ps
`default_nettype none

module gb_loader_top
	import gb_loader_pkg::*;
(
	input  wire logic           clk_sys,
	input  wire logic           reset,

	// Host download stream
	input  wire logic           host_download,
	input  wire file_index_t    host_index,
	input  wire logic           host_wr,
	input  wire host_addr_t     host_addr,
	input  wire host_word_t     host_data,

	// Boot option requests
	input  wire logic           is_gbc,
	input  wire logic           fast_boot_req,
	input  wire logic           gba_req,

	// Gated boot options
	output logic                fast_boot_en,
	output logic                boot_gba_en,
	output logic                real_cgb_boot,

	// Cheat engine side
	output cheat_code_t         cheat_code,
	output logic                code_valid,
	output logic                cheats_clear
);

	download_kind_t dl_kind;
	logic dl_start;
	logic dl_wr;
	host_addr_t dl_addr;
	host_word_t dl_data;

	////////////////////////////////
	// Decoder
	////////////////////////////////

	download_decoder u_download_decoder (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host_download (host_download),
		.host_index    (host_index),
		.host_wr       (host_wr),
		.host_addr     (host_addr),
		.host_data     (host_data),
		.dl_kind       (dl_kind),
		.dl_start      (dl_start),
		.dl_wr         (dl_wr),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data)
	);

	////////////////////////////////
	// Bootrom path
	////////////////////////////////

	bootrom_monitor u_bootrom_monitor (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_kind       (dl_kind),
		.dl_start      (dl_start),
		.dl_wr         (dl_wr),
		.dl_data       (dl_data),
		.is_gbc        (is_gbc),
		.fast_boot_req (fast_boot_req),
		.gba_req       (gba_req),
		.fast_boot_en  (fast_boot_en),
		.boot_gba_en   (boot_gba_en),
		.real_cgb_boot (real_cgb_boot)
	);

	////////////////////////////////
	// Cheat path
	////////////////////////////////

	cheat_code_loader u_cheat_code_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_kind      (dl_kind),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.cheat_code   (cheat_code),
		.code_valid   (code_valid),
		.cheats_clear (cheats_clear)
	);

endmodule

`default_nettype wire

/* sim/tb_gb_loader.sv */
// Testbench for the host loader that runs bootrom and cheat downloads and checks the outputs
`timescale 1ns/100ps
`default_nettype none

module tb_gb_loader
	import gb_loader_pkg::*;
();

	localparam int WAIT_LIMIT = 20;

	logic clk_sys;
	logic reset;
	logic host_download;
	file_index_t host_index;
	logic host_wr;
	host_addr_t host_addr;
	host_word_t host_data;
	logic is_gbc;
	logic fast_boot_req;
	logic gba_req;
	logic fast_boot_en;
	logic boot_gba_en;
	logic real_cgb_boot;
	cheat_code_t cheat_code;
	logic code_valid;
	logic cheats_clear;

	logic [31:0] lfsr_state = 32'hcdd4_5786;
	host_word_t word_buf [0:1023];
	host_addr_t addr_buf [0:1023];
	int errors = 0;
	int checks = 0;
	int valid_count = 0;
	int clear_count = 0;

	gb_loader_top u_gb_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Pulse counters sampled away from the rising edge
	always @(negedge clk_sys) begin
		if (code_valid === 1'b1)
			valid_count++;
		if (cheats_clear === 1'b1)
			clear_count++;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Byte sum of the first count words in the buffer
	function automatic checksum_t file_checksum(input int count);
		checksum_t sum;
		sum = '0;
		for (int i = 0; i < count; i++)
			sum = sum + checksum_t'(word_buf[i][15:8]) + checksum_t'(word_buf[i][7:0]);
		return sum;
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// Apply the requests, then sample the gate at the falling edge
	task automatic check_gate(input string name, input logic gbc, input logic fast,
		input logic gba, input logic exp_fast, input logic exp_gba, input logic exp_real);
		next_cycle();
		is_gbc = gbc;
		fast_boot_req = fast;
		gba_req = gba;
		@(negedge clk_sys);
		check_value($sformatf("%s fast_boot_en", name), exp_fast, fast_boot_en);
		check_value($sformatf("%s boot_gba_en", name), exp_gba, boot_gba_en);
		check_value($sformatf("%s real_cgb_boot", name), exp_real, real_cgb_boot);
	endtask

	task automatic random_file(input int count);
		for (int i = 0; i < count; i++) begin
			word_buf[i] = host_word_t'(random_bits(16));
			addr_buf[i] = host_addr_t'(2 * i);
		end
	endtask

	// Random head, then padding words that bring the byte sum to target
	task automatic build_cgb_file(input checksum_t target, output int count);
		checksum_t rest;
		checksum_t low;
		checksum_t high;
		random_file(32);
		count = 32;
		rest = target - file_checksum(32);
		while (rest != 0) begin
			low = (rest > 18'd255) ? 18'd255 : rest;
			rest = rest - low;
			high = (rest > 18'd255) ? 18'd255 : rest;
			rest = rest - high;
			word_buf[count] = {high[7:0], low[7:0]};
			addr_buf[count] = host_addr_t'(2 * count);
			count++;
		end
	endtask

	// One download with an optional check that cheats_clear stays high
	task automatic send_file(input file_index_t index, input int count, input bit watch_clear);
		next_cycle();
		host_download = 1'b1;
		host_index = index;
		for (int i = 0; i < count; i++) begin
			next_cycle();
			host_wr = 1'b1;
			host_addr = addr_buf[i];
			host_data = word_buf[i];
			next_cycle();
			host_wr = 1'b0;
			if (watch_clear) begin
				@(negedge clk_sys);
				check_value($sformatf("cheats_clear index %0h", index), 1, cheats_clear);
			end
		end
		next_cycle();
		host_download = 1'b0;
		// Two cycles of latency plus margin
		repeat (3) next_cycle();
	endtask

	task automatic wait_for_pulse(input bit clear_pulse, input int base, input string what);
		int waited;
		waited = 0;
		while ((clear_pulse ? clear_count : valid_count) == base && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		assert ((clear_pulse ? clear_count : valid_count) != base)
		else begin
			errors++;
			$display("Timed out waiting for %s", what);
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		checksum_t sum;
		cheat_code_t expected;
		cheat_code_t held;
		host_addr_t swap_addr;
		int count;
		int base;
		int top;
		int j;

		reset = 1'b1;
		host_download = 1'b0;
		host_index = '0;
		host_wr = 1'b0;
		host_addr = '0;
		host_data = '0;
		is_gbc = 1'b0;
		fast_boot_req = 1'b0;
		gba_req = 1'b0;
		repeat (5) @(posedge clk_sys);
		#2;
		reset = 1'b0;

		// Nothing loaded so requests pass straight through
		for (int k = 0; k < 8; k++)
			check_gate("reset", k[2], k[1], k[0], k[1], k[0], 1'b0);
		check_value("reset code_valid", 0, code_valid);
		check_value("reset cheats_clear", 0, cheats_clear);

		// Unknown CGB image blocks both options
		random_file(64);
		sum = file_checksum(64);
		send_file(INDEX_CGB_BOOT, 64, 1'b0);
		if (sum != MISTER_CGB_CHECKSUM && sum != ORIGINAL_CGB_CHECKSUM)
			check_gate("random cgb", 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
		build_cgb_file(MISTER_CGB_CHECKSUM, count);
		send_file(INDEX_CGB_BOOT, count, 1'b0);
		check_gate("in-house cgb", 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
		check_gate("in-house cgb", 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

		build_cgb_file(ORIGINAL_CGB_CHECKSUM, count);
		send_file(INDEX_CGB_BOOT, count, 1'b0);
		check_gate("original cgb", 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
		check_gate("original cgb", 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);

		// Files that must not touch the gate, then a custom DMG image
		base = clear_count;
		random_file(16);
		send_file(INDEX_SGB_BOOT, 16, 1'b0);
		check_gate("sgb boot", 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		send_file(8'h10, 16, 1'b0);
		check_gate("other index", 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		check_value("sgb and other cheats_clear pulses", 0, clear_count - base);
		send_file(INDEX_DMG_BOOT, 16, 1'b0);
		check_gate("dmg boot", 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);

		// Cheat with shuffled offsets
		random_file(8);
		for (int i = 7; i > 0; i--) begin
			j = int'(random_bits(8)) % (i + 1);
			swap_addr = addr_buf[i];
			addr_buf[i] = addr_buf[j];
			addr_buf[j] = swap_addr;
		end
		for (int i = 0; i < 8; i++) begin
			// Offset bits 3..2 pick the field, bit 1 the upper half
			top = 127 - 32 * int'(addr_buf[i][3:2]) - (addr_buf[i][1] ? 0 : 16);
			expected[top -: 16] = word_buf[i];
		end
		base = valid_count;
		send_file(INDEX_CHEAT, 8, 1'b0);
		wait_for_pulse(1'b0, base, "code_valid after the cheat file");
		check_value("cheat code_valid pulses", 1, valid_count - base);
		check_value("cheat code", expected, cheat_code);

		held = cheat_code;
		base = valid_count;
		random_file(8);
		send_file(8'h41, 8, 1'b0);
		check_value("cart words cheat code", held, cheat_code);
		check_value("cart words code_valid pulses", 0, valid_count - base);

		// Clear request from offset 0, then held through cartridge loads
		check_value("idle cheats_clear", 0, cheats_clear);
		base = clear_count;
		random_file(1);
		send_file(INDEX_CHEAT, 1, 1'b0);
		wait_for_pulse(1'b1, base, "cheats_clear after a cheat write at offset 0");
		random_file(8);
		send_file(INDEX_CART_ALT, 8, 1'b1);
		send_file(8'h41, 8, 1'b1);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hdl/gb_loader_pkg.sv
hdl/download_decoder.sv
hdl/bootrom_monitor.sv
hdl/cheat_code_loader.sv
hdl/gb_loader_top.sv
sim/tb_gb_loader.sv
